// File: all.f
+incdir+.
lsu_pkg.sv
lsu_align.sv
lsu_store_queue.sv
lsu_load_unit.sv
lsu_mem_arbiter.sv
lsu_top.sv
tb_lsu.sv

// File: lsu_align.sv
/*
 * Access alignment.
 * Builds the byte strobe for an access size at a word offset and moves
 * right-aligned store data into its byte lanes.
 */

`include "lsu_defs.svh"

module lsu_align (
    input  lsu_pkg::size_t         size,
    input  logic [`LSU_OFS_W-1:0]  offset,
    input  lsu_pkg::data_t         wdata,
    output lsu_pkg::strb_t         strb,
    output lsu_pkg::data_t         wdata_aligned
);

    lsu_pkg::strb_t base_strb; // mask at offset zero

    always_comb begin
        case (size)
            lsu_pkg::sz_byte: base_strb = 8'b0000_0001;
            lsu_pkg::sz_half: base_strb = 8'b0000_0011;
            lsu_pkg::sz_word: base_strb = 8'b0000_1111;
            default:          base_strb = 8'b1111_1111;
        endcase
    end

    assign strb = base_strb << offset;

    // offset in bytes, shift in bits
    assign wdata_aligned = wdata << {offset, 3'b000};

endmodule

// File: lsu_defs.svh
/*
 * Load-store unit widths and sizes.
 * Word, address, strobe and store queue dimensions shared by the design.
 */

`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// one data word
`define LSU_DATA_W 64

// byte address
`define LSU_ADDR_W 32

// bytes per word, one strobe bit each
`define LSU_STRB_W 8

// byte offset inside a word
`define LSU_OFS_W 3

// store queue entries and pointer width
`define LSU_SQ_DEPTH 8
`define LSU_SQ_IDX_W 3

`endif

// File: lsu_load_unit.sv
/*
 * Load unit.
 * Single in-flight load. Checks the store queue, forwards a covering store,
 * waits out partial overlaps or reads memory, then returns aligned data.
 */

`include "lsu_defs.svh"

module lsu_load_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  lsu_pkg::addr_t      addr,
    input  lsu_pkg::size_t      size,
    input  lsu_pkg::strb_t      strb,
    output logic                busy,
    output lsu_pkg::word_addr_t lookup_addr,
    output lsu_pkg::strb_t      lookup_strb,
    input  logic                overlap,
    input  logic                fwd_hit,
    input  lsu_pkg::data_t      fwd_data,
    output logic                rd_req,
    output lsu_pkg::word_addr_t rd_addr,
    input  logic                rd_ack,
    input  lsu_pkg::data_t      rd_data,
    output logic                load_valid,
    output lsu_pkg::data_t      load_data
);

    lsu_pkg::load_state_t state;
    lsu_pkg::addr_t       addr_q;
    lsu_pkg::size_t       size_q;
    lsu_pkg::strb_t       strb_q;
    lsu_pkg::data_t       word_q; // full word, forwarded or read
    lsu_pkg::data_t       size_mask;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= lsu_pkg::ld_idle;
        end else begin
            case (state)
                lsu_pkg::ld_idle:  if (start) state <= lsu_pkg::ld_check;
                lsu_pkg::ld_check: begin
                    if (fwd_hit)      state <= lsu_pkg::ld_resp;
                    else if (overlap) state <= lsu_pkg::ld_wait; // partial cover
                    else              state <= lsu_pkg::ld_mem;
                end
                lsu_pkg::ld_wait:  if (!overlap) state <= lsu_pkg::ld_mem;
                lsu_pkg::ld_mem:   if (rd_ack) state <= lsu_pkg::ld_resp;
                default:           state <= lsu_pkg::ld_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == lsu_pkg::ld_idle && start) begin
            addr_q <= addr;
            size_q <= size;
            strb_q <= strb;
        end
        if (state == lsu_pkg::ld_check && fwd_hit) word_q <= fwd_data;
        if (state == lsu_pkg::ld_mem && rd_ack)    word_q <= rd_data;
    end

    assign busy        = state != lsu_pkg::ld_idle;
    assign lookup_addr = addr_q[`LSU_ADDR_W-1:`LSU_OFS_W];
    assign lookup_strb = strb_q;
    assign rd_req      = state == lsu_pkg::ld_mem;
    assign rd_addr     = addr_q[`LSU_ADDR_W-1:`LSU_OFS_W];

    always_comb begin
        case (size_q)
            lsu_pkg::sz_byte: size_mask = 64'h0000_0000_0000_00ff;
            lsu_pkg::sz_half: size_mask = 64'h0000_0000_0000_ffff;
            lsu_pkg::sz_word: size_mask = 64'h0000_0000_ffff_ffff;
            default:          size_mask = '1;
        endcase
    end

    assign load_valid = state == lsu_pkg::ld_resp;
    assign load_data  = (word_q >> {addr_q[`LSU_OFS_W-1:0], 3'b000}) & size_mask; // zero-extend

endmodule

// File: lsu_mem_arbiter.sv
/*
 * Memory port arbiter.
 * Shares one memory port between load reads and store drain. Loads win
 * when idle; a started request keeps the port until mem_ack.
 */

module lsu_mem_arbiter (
    input  logic                clk,
    input  logic                rst,
    input  logic                rd_req,
    input  lsu_pkg::word_addr_t rd_addr,
    output logic                rd_ack,
    output lsu_pkg::data_t      rd_data,
    input  logic                drain_req,
    input  lsu_pkg::word_addr_t drain_addr,
    input  lsu_pkg::strb_t      drain_strb,
    input  lsu_pkg::data_t      drain_wdata,
    output logic                drain_ack,
    output logic                mem_req,
    output logic                mem_we,
    output lsu_pkg::word_addr_t mem_addr,
    output lsu_pkg::strb_t      mem_strb,
    output lsu_pkg::data_t      mem_wdata,
    input  logic                mem_ack,
    input  lsu_pkg::data_t      mem_rdata
);

    logic locked;    // request outstanding
    logic locked_rd; // owner of the outstanding request
    logic sel_rd;

    assign sel_rd = locked ? locked_rd : rd_req;

    assign mem_req   = sel_rd ? rd_req : drain_req;
    assign mem_we    = mem_req & ~sel_rd;
    assign mem_addr  = sel_rd ? rd_addr : drain_addr;
    assign mem_strb  = sel_rd ? '0 : drain_strb;
    assign mem_wdata = sel_rd ? '0 : drain_wdata;

    assign rd_ack    = mem_ack & sel_rd;
    assign drain_ack = mem_ack & ~sel_rd;
    assign rd_data   = mem_rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            locked    <= 1'b0;
            locked_rd <= 1'b0;
        end else if (mem_req && !mem_ack) begin
            locked    <= 1'b1;
            locked_rd <= sel_rd;
        end else if (mem_ack) begin
            locked <= 1'b0;
        end
    end

endmodule

// File: lsu_pkg.sv
/*
 * Load-store unit types.
 * Vector types for addresses, data and strobes, plus the access size and
 * load FSM state encodings.
 */

`include "lsu_defs.svh"

package lsu_pkg;

    typedef logic [`LSU_ADDR_W-1:0]            addr_t;      // byte address
    typedef logic [`LSU_ADDR_W-`LSU_OFS_W-1:0] word_addr_t; // word-aligned address
    typedef logic [`LSU_DATA_W-1:0]            data_t;
    typedef logic [`LSU_STRB_W-1:0]            strb_t;      // byte enables
    typedef logic [`LSU_SQ_IDX_W-1:0]          sq_idx_t;    // store queue pointer

    // access size, log2 of the byte count
    typedef enum logic [1:0] {sz_byte, sz_half, sz_word, sz_double} size_t;

    typedef enum logic [2:0] {
        ld_idle,
        ld_check,
        ld_wait,
        ld_mem,
        ld_resp
    } load_state_t;

endpackage

// File: lsu_store_queue.sv
/*
 * Store queue.
 * Circular in-order buffer of stores. Committed entries drain from the head
 * to memory one at a time, and loads search it for older overlapping stores.
 */

`include "lsu_defs.svh"

module lsu_store_queue (
    input  logic                clk,
    input  logic                rst,
    input  logic                alloc,
    input  lsu_pkg::word_addr_t alloc_addr,
    input  lsu_pkg::strb_t      alloc_strb,
    input  lsu_pkg::data_t      alloc_data,
    input  logic                commit,
    output logic                full,
    input  lsu_pkg::word_addr_t lookup_addr,
    input  lsu_pkg::strb_t      lookup_strb,
    output logic                overlap,
    output logic                fwd_hit,
    output lsu_pkg::data_t      fwd_data,
    output logic                drain_req,
    output lsu_pkg::word_addr_t drain_addr,
    output lsu_pkg::strb_t      drain_strb,
    output lsu_pkg::data_t      drain_wdata,
    input  logic                drain_ack
);

    lsu_pkg::sq_idx_t head; // oldest entry
    lsu_pkg::sq_idx_t cmt;  // oldest uncommitted entry
    lsu_pkg::sq_idx_t tail; // next free slot

    logic [`LSU_SQ_DEPTH-1:0] valid;
    logic [`LSU_SQ_DEPTH-1:0] committed;

    lsu_pkg::word_addr_t sq_addr [`LSU_SQ_DEPTH];
    lsu_pkg::strb_t      sq_strb [`LSU_SQ_DEPTH];
    lsu_pkg::data_t      sq_data [`LSU_SQ_DEPTH];

    assign full = &valid;

    // head entry goes out once committed
    assign drain_req   = valid[head] & committed[head];
    assign drain_addr  = sq_addr[head];
    assign drain_strb  = sq_strb[head];
    assign drain_wdata = sq_data[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            head      <= '0;
            cmt       <= '0;
            tail      <= '0;
            valid     <= '0;
            committed <= '0;
        end else begin
            if (alloc) begin
                valid[tail]     <= 1'b1;
                committed[tail] <= 1'b0;
                tail            <= tail + 1'b1;
            end
            if (commit) begin
                committed[cmt] <= 1'b1;
                cmt            <= cmt + 1'b1;
            end
            if (drain_req && drain_ack) begin // entry written, free it
                valid[head]     <= 1'b0;
                committed[head] <= 1'b0;
                head            <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            sq_addr[tail] <= alloc_addr;
            sq_strb[tail] <= alloc_strb;
            sq_data[tail] <= alloc_data;
        end
    end

    // youngest-first search, the first match decides forwarding
    always_comb begin
        lsu_pkg::sq_idx_t idx;
        logic             found;

        found    = 1'b0;
        fwd_hit  = 1'b0;
        fwd_data = '0;
        for (int i = 0; i < `LSU_SQ_DEPTH; i++) begin
            idx = tail - lsu_pkg::sq_idx_t'(i + 1);
            if (!found && valid[idx] && sq_addr[idx] == lookup_addr
                    && |(sq_strb[idx] & lookup_strb)) begin
                found    = 1'b1;
                fwd_hit  = ~|(lookup_strb & ~sq_strb[idx]); // covers every load byte
                fwd_data = sq_data[idx];
            end
        end
        overlap = found;
    end

endmodule

// File: lsu_top.sv
/*
 * Load-store unit top level.
 * Splits requests into store queue allocation or load start and joins the
 * load and drain traffic onto one memory port.
 */

`include "lsu_defs.svh"

module lsu_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    input  logic                req_store,
    input  lsu_pkg::size_t      req_size,
    input  lsu_pkg::addr_t      req_addr,
    input  lsu_pkg::data_t      req_wdata,
    output logic                req_ready,
    input  logic                commit,
    output logic                load_valid,
    output lsu_pkg::data_t      load_data,
    output logic                mem_req,
    output logic                mem_we,
    output lsu_pkg::word_addr_t mem_addr,
    output lsu_pkg::strb_t      mem_strb,
    output lsu_pkg::data_t      mem_wdata,
    input  logic                mem_ack,
    input  lsu_pkg::data_t      mem_rdata
);

    lsu_pkg::word_addr_t req_word; // word part of the request address
    lsu_pkg::strb_t      st_strb, ld_strb, lookup_strb, drain_strb;
    lsu_pkg::data_t      st_wdata, fwd_data, drain_wdata, rd_data;
    lsu_pkg::word_addr_t lookup_addr, drain_addr, rd_addr;
    logic                busy, full, overlap, fwd_hit;
    logic                drain_req, drain_ack, rd_req, rd_ack;

    assign req_word  = req_addr[`LSU_ADDR_W-1:`LSU_OFS_W];
    assign req_ready = ~busy & ~full;

    lsu_align u_st_align (
        .size(req_size), .offset(req_addr[`LSU_OFS_W-1:0]), .wdata(req_wdata),
        .strb(st_strb), .wdata_aligned(st_wdata)
    );

    lsu_align u_ld_align ( // load only needs the strobe
        .size(req_size), .offset(req_addr[`LSU_OFS_W-1:0]), .wdata('0),
        .strb(ld_strb), .wdata_aligned()
    );

    lsu_store_queue u_sq (
        .clk(clk), .rst(rst),
        .alloc(req_valid & req_store), .alloc_addr(req_word),
        .alloc_strb(st_strb), .alloc_data(st_wdata),
        .commit(commit), .full(full),
        .lookup_addr(lookup_addr), .lookup_strb(lookup_strb),
        .overlap(overlap), .fwd_hit(fwd_hit), .fwd_data(fwd_data),
        .drain_req(drain_req), .drain_addr(drain_addr), .drain_strb(drain_strb),
        .drain_wdata(drain_wdata), .drain_ack(drain_ack)
    );

    lsu_load_unit u_ld (
        .clk(clk), .rst(rst),
        .start(req_valid & ~req_store), .addr(req_addr), .size(req_size), .strb(ld_strb),
        .busy(busy), .lookup_addr(lookup_addr), .lookup_strb(lookup_strb),
        .overlap(overlap), .fwd_hit(fwd_hit), .fwd_data(fwd_data),
        .rd_req(rd_req), .rd_addr(rd_addr), .rd_ack(rd_ack), .rd_data(rd_data),
        .load_valid(load_valid), .load_data(load_data)
    );

    lsu_mem_arbiter u_arb (
        .clk(clk), .rst(rst),
        .rd_req(rd_req), .rd_addr(rd_addr), .rd_ack(rd_ack), .rd_data(rd_data),
        .drain_req(drain_req), .drain_addr(drain_addr), .drain_strb(drain_strb),
        .drain_wdata(drain_wdata), .drain_ack(drain_ack),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_strb(mem_strb),
        .mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata)
    );

endmodule

// File: run.sh
#!/bin/sh
# build and run the load-store unit testbench with Verilator

verilator --binary --timing --top-module tb_lsu -f all.f -o tb_lsu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_lsu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" sim.log; then
    exit 1
fi
exit 0

// File: tb_lsu.sv
/*
 * Load-store unit testbench.
 * Random loads and stores over a four-word window against a byte model,
 * with a memory that acknowledges after a random delay.
 */

`include "lsu_defs.svh"

module tb_lsu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_REQ   = 2000;
    localparam int N_WORDS = 4;

    logic                clk = 1'b0;
    logic                rst, req_valid, req_store, commit;
    lsu_pkg::size_t      req_size;
    lsu_pkg::addr_t      req_addr;
    lsu_pkg::data_t      req_wdata, load_data, mem_wdata;
    logic                req_ready, load_valid, mem_req, mem_we;
    lsu_pkg::word_addr_t mem_addr;
    lsu_pkg::strb_t      mem_strb;
    logic                mem_ack = 1'b0;
    lsu_pkg::data_t      mem_rdata = '0;

    logic [7:0]     ref_mem [N_WORDS*8]; // byte model, updated at store accept
    lsu_pkg::data_t dut_mem [N_WORDS];   // memory behind the DUT port
    int             sq_word [$];         // stores not yet written to memory
    lsu_pkg::strb_t sq_strb [$];
    lsu_pkg::data_t sq_data [$];
    int             n_cmt_q, n_err, n_loads, n_drains, n_full;
    logic           ld_pend, ld_hit, after_rst, mem_busy;
    int             ld_age, mem_dly;
    lsu_pkg::data_t ld_exp, wdata_q;
    lsu_pkg::word_addr_t addr_q;
    lsu_pkg::strb_t strb_q;
    logic           we_q;
    logic [31:0]    mem_rng;

    lsu_top u_dut (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req_store(req_store),
        .req_size(req_size), .req_addr(req_addr), .req_wdata(req_wdata),
        .req_ready(req_ready), .commit(commit), .load_valid(load_valid),
        .load_data(load_data), .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_strb(mem_strb), .mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [7:0] fill_byte(input int a);
        return 8'(a * 59 + 165); // distinct for every byte address in the window
    endfunction

    function automatic lsu_pkg::strb_t strb_for(input int sz, input int ofs);
        lsu_pkg::strb_t s;
        s = '0;
        for (int b = 0; b < (1 << sz); b++) s[ofs+b] = 1'b1;
        return s;
    endfunction

    function automatic lsu_pkg::data_t lane_data(input lsu_pkg::data_t d, input int sz,
                                                 input int ofs);
        lsu_pkg::data_t r;
        r = '0;
        for (int b = 0; b < (1 << sz); b++) r[(ofs+b)*8 +: 8] = d[b*8 +: 8];
        return r;
    endfunction

    function automatic lsu_pkg::data_t byte_mask(input lsu_pkg::strb_t s);
        lsu_pkg::data_t m;
        for (int b = 0; b < 8; b++) m[b*8 +: 8] = {8{s[b]}};
        return m;
    endfunction

    // memory responder, queue shadow and response checks
    always @(posedge clk) begin : monitor
        int w, o, sz;
        logic found;
        lsu_pkg::strb_t ls;
        mem_ack <= 1'b0;
        if (rst) begin
            for (int i = 0; i < N_WORDS * 8; i++) begin
                ref_mem[i] = fill_byte(i);
                dut_mem[i/8][(i%8)*8 +: 8] = fill_byte(i);
            end
            sq_word.delete();
            sq_strb.delete();
            sq_data.delete();
            mem_rng   = lcg(32'd68649);
            n_cmt_q   = 0;
            n_err     = 0;
            n_loads   = 0;
            n_drains  = 0;
            n_full    = 0;
            ld_pend   = 1'b0;
            mem_busy  = 1'b0;
            after_rst = 1'b1;
        end else begin
            if (after_rst) begin
                assert (!load_valid && !mem_req && req_ready) else begin
                    n_err++;
                    $display("FAIL %0t: outputs not idle after reset", $time);
                end
                after_rst = 1'b0;
            end
            assert (req_ready == (sq_word.size() < `LSU_SQ_DEPTH && !ld_pend)) else begin
                n_err++;
                $display("FAIL %0t: req_ready %0b with %0d queued stores", $time, req_ready,
                         sq_word.size());
            end
            if (sq_word.size() == `LSU_SQ_DEPTH) n_full++; // queue full this cycle
            // memory side: hold checks, then delayed acknowledge
            if (!mem_busy && mem_req && !mem_ack) begin
                addr_q   = mem_addr;
                we_q     = mem_we;
                strb_q   = mem_strb;
                wdata_q  = mem_wdata;
                mem_rng  = lcg(mem_rng);
                mem_dly  = int'(mem_rng[17:16]);
                mem_busy = 1'b1;
            end else if (mem_busy) begin
                assert (mem_req && mem_we == we_q && mem_addr == addr_q
                        && mem_strb == strb_q && mem_wdata == wdata_q) else begin
                    n_err++;
                    $display("FAIL %0t: memory request changed before mem_ack", $time);
                end
            end
            if (mem_busy) begin
                if (mem_dly == 0) begin
                    w = int'(addr_q[1:0]);
                    mem_ack   <= 1'b1;
                    mem_rdata <= dut_mem[w];
                    if (we_q)
                        for (int b = 0; b < 8; b++)
                            if (strb_q[b]) dut_mem[w][b*8 +: 8] = wdata_q[b*8 +: 8];
                    mem_busy = 1'b0;
                end else begin
                    mem_dly--;
                end
            end
            if (mem_ack && mem_we) begin // drain completes, oldest committed store
                assert (sq_word.size() > 0 && n_cmt_q > 0 && int'(mem_addr) == sq_word[0]
                        && mem_strb == sq_strb[0]
                        && ((mem_wdata ^ sq_data[0]) & byte_mask(mem_strb)) == '0) else begin
                    n_err++;
                    $display("FAIL %0t: memory write out of order or uncommitted", $time);
                end
                if (sq_word.size() > 0) begin
                    void'(sq_word.pop_front());
                    void'(sq_strb.pop_front());
                    void'(sq_data.pop_front());
                end
                n_cmt_q--;
                n_drains++;
            end
            if (commit) n_cmt_q++;
            assert (!load_valid || ld_pend) else begin
                n_err++;
                $display("FAIL %0t: load_valid without a load in flight", $time);
            end
            if (ld_pend) begin
                ld_age++;
                if (load_valid) begin
                    assert (load_data == ld_exp) else begin
                        n_err++;
                        $display("FAIL %0t: load data %h expected %h", $time, load_data, ld_exp);
                    end
                    assert (!ld_hit || ld_age == 2) else begin
                        n_err++;
                        $display("FAIL %0t: forwarded load took %0d cycles", $time, ld_age);
                    end
                    ld_pend = 1'b0;
                    n_loads++;
                end
            end
            if (req_valid) begin
                w  = int'(req_addr[4:3]);
                o  = int'(req_addr[2:0]);
                sz = int'(req_size);
                ls = strb_for(sz, o);
                if (req_store) begin
                    for (int b = 0; b < (1 << sz); b++) ref_mem[w*8+o+b] = req_wdata[b*8 +: 8];
                    sq_word.push_back(w);
                    sq_strb.push_back(ls);
                    sq_data.push_back(lane_data(req_wdata, sz, o));
                end else begin
                    ld_exp = '0;
                    for (int b = 0; b < (1 << sz); b++) ld_exp[b*8 +: 8] = ref_mem[w*8+o+b];
                    found  = 1'b0;
                    ld_hit = 1'b0;
                    for (int i = sq_word.size() - 1; i >= 0; i--) begin // youngest first
                        if (!found && sq_word[i] == w && (sq_strb[i] & ls) != '0) begin
                            found  = 1'b1;
                            ld_hit = (ls & ~sq_strb[i]) == '0;
                        end
                    end
                    ld_pend = 1'b1;
                    ld_age  = 0;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (N_REQ * 40) @(posedge clk);
        $display("timeout: the run did not finish in %0d cycles", N_REQ * 40);
        $display("test failed");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] rng;
        logic        hold_cmt;
        int n_req, n_acc, n_st, n_cmt, sz, ofs, n_bad, cyc;
        rng       = 32'd68649;
        n_req     = 0;
        n_acc     = 0;
        n_st      = 0;
        n_cmt     = 0;
        n_bad     = 0;
        cyc       = 0;
        rst       = 1'b1;
        req_valid = 1'b0;
        req_store = 1'b0;
        commit    = 1'b0;
        req_size  = lsu_pkg::sz_byte;
        req_addr  = '0;
        req_wdata = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        while (n_acc < N_REQ || n_cmt < n_st) begin
            @(posedge clk);
            req_valid <= 1'b0;
            commit    <= 1'b0;
            if (req_valid) n_acc++;
            if (req_valid && req_store) n_st++;
            cyc++;
            hold_cmt = cyc % 256 >= 192; // stores only, no commits, so the queue fills
            rng = lcg(rng);
            if (n_cmt < n_st && !hold_cmt && rng[17:16] == 2'd0) begin
                commit <= 1'b1;
                n_cmt++;
            end
            rng = lcg(rng);
            if (n_req < N_REQ && !req_valid && req_ready && rng[16]) begin
                sz  = int'(rng[19:18]);
                ofs = int'(rng[22:20]) & ~((1 << sz) - 1); // naturally aligned
                req_valid <= 1'b1;
                req_store <= rng[23] | hold_cmt;
                req_size  <= lsu_pkg::size_t'(rng[19:18]);
                req_addr  <= lsu_pkg::addr_t'(int'(rng[25:24]) * 8 + ofs);
                rng = lcg(rng);
                req_wdata[63:32] <= rng;
                rng = lcg(rng);
                req_wdata[31:0] <= rng;
                n_req++;
            end
        end
        @(posedge clk);
        req_valid <= 1'b0;
        commit    <= 1'b0; // end of the last commit pulse
        @(posedge clk);
        while (ld_pend || sq_word.size() != 0) @(posedge clk);
        for (int i = 0; i < N_WORDS * 8; i++) begin
            assert (dut_mem[i/8][(i%8)*8 +: 8] == ref_mem[i]) else begin
                n_bad++;
                $display("FAIL %0t: memory byte %0d is %h expected %h", $time, i,
                         dut_mem[i/8][(i%8)*8 +: 8], ref_mem[i]);
            end
        end
        assert (n_full > 0) else begin
            n_bad++;
            $display("the store queue never reached full occupancy");
        end
        $display("loads %0d drains %0d errors %0d", n_loads, n_drains, n_err + n_bad);
        if (n_err + n_bad == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
